// ==== design/vera_bus_pkg.sv ====
package vera_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Register bus
    ////////////////////////////////////////////////////////////

    // Host byte address, covers 00000-7FFFF
    typedef logic [18:0] regbus_addr_t;
    typedef logic [7:0]  reg_data_t;

    typedef struct packed {
        regbus_addr_t addr;
        reg_data_t    wrdata;
        logic         strobe;
        logic         write;
    } regbus_req_t;

    ////////////////////////////////////////////////////////////
    // Memory bus
    ////////////////////////////////////////////////////////////

    // Byte address on the shared 32-bit bus
    typedef logic [17:0] mem_addr_t;
    typedef logic [31:0] mem_word_t;
    typedef logic [3:0]  byte_sel_t;

    typedef struct packed {
        mem_addr_t addr;
        logic      strobe;
        logic      write;
    } mem_req_t;

    // Decoded regions of the register-bus memory map
    typedef enum logic [1:0] {
        REGION_NONE    = 2'd0,
        REGION_MAINRAM = 2'd1,
        REGION_PALETTE = 2'd2
    } region_t;

endpackage

// ==== design/vera_video_pkg.sv ====
package vera_video_pkg;

    // Pixel value from the renderers, indexes the palette
    typedef logic [7:0] palette_idx_t;

    // Stored palette word, only the low 12 bits reach the display
    typedef logic [15:0] palette_entry_t;

    // 4 bits each of R, G and B, red on top
    typedef logic [11:0] rgb12_t;

endpackage

// ==== design/main_ram.sv ====
`timescale 1ns/1ps

module main_ram #(
    parameter int MAIN_RAM_ADDR_BITS = 15
) (
    input  logic                          clk,
    input  logic [MAIN_RAM_ADDR_BITS-1:0] addr_i,
    input  vera_bus_pkg::mem_word_t       wrdata_i,
    input  vera_bus_pkg::byte_sel_t       bytesel_i,
    input  logic                          write_i,
    output vera_bus_pkg::mem_word_t       rddata_o
);

    import vera_bus_pkg::*;

    localparam int DEPTH = 2 ** MAIN_RAM_ADDR_BITS;

    mem_word_t mem [DEPTH];

    // Per-lane write, old word is returned on a write cycle
    always_ff @(posedge clk) begin
        if (write_i) begin
            for (int i = 0; i < 4; i++) begin
                if (bytesel_i[i]) begin
                    mem[addr_i][i*8 +: 8] <= wrdata_i[i*8 +: 8];
                end
            end
        end
        rddata_o <= mem[addr_i];
    end

endmodule

// ==== design/membus_arbiter.sv ====
`timescale 1ns/1ps

module membus_arbiter #(
    parameter int MAIN_RAM_ADDR_BITS = 15
) (
    input  logic                    clk,
    input  logic                    reset,

    // Host port from the register-bus decoder
    input  vera_bus_pkg::mem_req_t  mem_req_i,
    input  vera_bus_pkg::reg_data_t wrdata_i,

    // Display fetch master, word addressed
    input  logic                    fetch_strobe_i,
    input  logic [15:0]             fetch_addr_i,
    output logic                    fetch_ack_o,
    output vera_bus_pkg::mem_word_t fetch_data_o,

    output vera_bus_pkg::mem_word_t mem_rddata_o
);

    import vera_bus_pkg::*;

    logic      fetch_grant;
    mem_addr_t bus_addr;
    mem_word_t bus_wrdata;
    byte_sel_t bus_bytesel;
    logic      bus_write;
    mem_word_t ram_rddata;

    // Host has fixed priority, fetch takes any idle cycle
    assign fetch_grant = fetch_strobe_i && !mem_req_i.strobe;

    assign bus_addr   = mem_req_i.strobe ? mem_req_i.addr : {fetch_addr_i, 2'b00};
    assign bus_write  = mem_req_i.strobe && mem_req_i.write;
    assign bus_wrdata = {4{wrdata_i}};

    // One lane per host byte
    always_comb begin
        bus_bytesel = '0;
        bus_bytesel[bus_addr[1:0]] = 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ack_o <= 1'b0;
        end else begin
            fetch_ack_o <= fetch_grant;
        end
    end

    main_ram #(
        .MAIN_RAM_ADDR_BITS (MAIN_RAM_ADDR_BITS)
    ) u_main_ram (
        .clk       (clk),
        .addr_i    (bus_addr[MAIN_RAM_ADDR_BITS+1:2]),
        .wrdata_i  (bus_wrdata),
        .bytesel_i (bus_bytesel),
        .write_i   (bus_write),
        .rddata_o  (ram_rddata)
    );

    // Both masters see the same read word
    assign mem_rddata_o = ram_rddata;
    assign fetch_data_o = ram_rddata;

    // Host access blocks the grant, so no ack follows it
    assert property (@(posedge clk) disable iff (reset)
        mem_req_i.strobe |=> !fetch_ack_o);

endmodule

// ==== design/palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
    input  logic                         clk,
    input  logic                         reset,

    // Host byte port, bit 0 picks the byte of an entry
    input  logic                         host_wr_i,
    input  logic [8:0]                   host_addr_i,
    input  vera_bus_pkg::reg_data_t      host_wrdata_i,
    output vera_bus_pkg::reg_data_t      host_rddata_o,

    // Display lookup
    input  vera_video_pkg::palette_idx_t pixel_idx_i,
    output vera_video_pkg::rgb12_t       pixel_rgb_o
);

    import vera_video_pkg::*;

    palette_entry_t mem [256];
    palette_entry_t host_q;
    palette_entry_t pixel_q;
    logic           host_hi_r;

    // Even address writes the low byte, odd the high byte
    always_ff @(posedge clk) begin
        if (host_wr_i) begin
            if (host_addr_i[0]) begin
                mem[host_addr_i[8:1]][15:8] <= host_wrdata_i;
            end else begin
                mem[host_addr_i[8:1]][7:0] <= host_wrdata_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        host_q    <= mem[host_addr_i[8:1]];
        host_hi_r <= host_addr_i[0];
        pixel_q   <= mem[pixel_idx_i];
    end

    assign host_rddata_o = host_hi_r ? host_q[15:8] : host_q[7:0];

    // Top nibble of an entry is unused
    assign pixel_rgb_o = pixel_q[11:0];

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(pixel_idx_i));

endmodule

// ==== design/regbus_decoder.sv ====
`timescale 1ns/1ps

module regbus_decoder (
    input  logic                      clk,
    input  logic                      reset,

    input  vera_bus_pkg::regbus_req_t regbus_req_i,

    // Memory bus side
    output vera_bus_pkg::mem_req_t    mem_req_o,
    input  vera_bus_pkg::mem_word_t   mem_rddata_i,

    // Palette side
    output logic                      pal_wr_o,
    output logic [8:0]                pal_addr_o,
    output vera_bus_pkg::reg_data_t   pal_wrdata_o,
    input  vera_bus_pkg::reg_data_t   pal_rddata_i,

    output vera_bus_pkg::reg_data_t   rddata_o
);

    import vera_bus_pkg::*;

    region_t    region;
    region_t    region_r;
    logic [1:0] lane_r;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    // 00000-1FFFF main RAM, 40200-403FF palette, rest reads zero
    always_comb begin
        region = REGION_NONE;
        if (regbus_req_i.addr[18:17] == 2'b00) begin
            region = REGION_MAINRAM;
        end else if (regbus_req_i.addr[18] && regbus_req_i.addr[17:9] == 9'd1) begin
            region = REGION_PALETTE;
        end
    end

    // Main RAM accesses go out on the memory bus
    assign mem_req_o.addr   = regbus_req_i.addr[17:0];
    assign mem_req_o.write  = regbus_req_i.write;
    assign mem_req_o.strobe = regbus_req_i.strobe && (region == REGION_MAINRAM);

    // Palette reads need no strobe, the readback port follows the address
    assign pal_addr_o   = regbus_req_i.addr[8:0];
    assign pal_wrdata_o = regbus_req_i.wrdata;
    assign pal_wr_o     = regbus_req_i.strobe && regbus_req_i.write &&
                          (region == REGION_PALETTE);

    ////////////////////////////////////////////////////////////
    // Read data, one cycle after the strobe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            region_r <= REGION_NONE;
        end else begin
            region_r <= regbus_req_i.strobe ? region : REGION_NONE;
        end
    end

    always_ff @(posedge clk) begin
        lane_r <= regbus_req_i.addr[1:0];
    end

    always_comb begin
        case (region_r)
            REGION_MAINRAM: rddata_o = mem_rddata_i[lane_r*8 +: 8];
            REGION_PALETTE: rddata_o = pal_rddata_i;
            default:        rddata_o = '0;
        endcase
    end

    // One host access reaches at most one target
    assert property (@(posedge clk) disable iff (reset)
        !(mem_req_o.strobe && pal_wr_o));

endmodule

// ==== design/vera_core.sv ====
`timescale 1ns/1ps

module vera_core #(
    parameter int MAIN_RAM_ADDR_BITS = 15
) (
    input  logic                         clk,
    input  logic                         reset,

    // Host register bus
    input  vera_bus_pkg::regbus_req_t    regbus_req_i,
    output vera_bus_pkg::reg_data_t      rddata_o,

    // Display fetch master
    input  logic                         fetch_strobe_i,
    input  logic [15:0]                  fetch_addr_i,
    output logic                         fetch_ack_o,
    output vera_bus_pkg::mem_word_t      fetch_data_o,

    // Palette lookup
    input  vera_video_pkg::palette_idx_t pixel_idx_i,
    output vera_video_pkg::rgb12_t       pixel_rgb_o
);

    import vera_bus_pkg::*;

    mem_req_t  mem_req;
    mem_word_t mem_rddata;

    logic       pal_wr;
    logic [8:0] pal_addr;
    reg_data_t  pal_wrdata;
    reg_data_t  pal_rddata;

    regbus_decoder u_decoder (
        .clk          (clk),
        .reset        (reset),
        .regbus_req_i (regbus_req_i),
        .mem_req_o    (mem_req),
        .mem_rddata_i (mem_rddata),
        .pal_wr_o     (pal_wr),
        .pal_addr_o   (pal_addr),
        .pal_wrdata_o (pal_wrdata),
        .pal_rddata_i (pal_rddata),
        .rddata_o     (rddata_o)
    );

    // Host write byte comes straight from the register bus
    membus_arbiter #(
        .MAIN_RAM_ADDR_BITS (MAIN_RAM_ADDR_BITS)
    ) u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .mem_req_i      (mem_req),
        .wrdata_i       (regbus_req_i.wrdata),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_data_o   (fetch_data_o),
        .mem_rddata_o   (mem_rddata)
    );

    palette_ram u_palette (
        .clk           (clk),
        .reset         (reset),
        .host_wr_i     (pal_wr),
        .host_addr_i   (pal_addr),
        .host_wrdata_i (pal_wrdata),
        .host_rddata_o (pal_rddata),
        .pixel_idx_i   (pixel_idx_i),
        .pixel_rgb_o   (pixel_rgb_o)
    );

endmodule

// ==== verification/vera_core_checker.sv ====
`timescale 1ns/1ps

module vera_core_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  vera_bus_pkg::regbus_req_t    regbus_req_i,
    input  vera_bus_pkg::reg_data_t      rddata_i,
    input  logic                         fetch_strobe_i,
    input  logic [15:0]                  fetch_addr_i,
    input  logic                         fetch_ack_i,
    input  vera_bus_pkg::mem_word_t      fetch_data_i,
    input  vera_video_pkg::palette_idx_t pixel_idx_i,
    input  vera_video_pkg::rgb12_t       pixel_rgb_i,
    output int                           value_errors_o,
    output int                           protocol_errors_o
);

    import vera_bus_pkg::*;
    import vera_video_pkg::*;

    // Byte models of main RAM and palette
    reg_data_t ram_model [131072];
    reg_data_t pal_model [512];
    logic      pal_written [512];

    int           value_errors = 0;
    int           protocol_errors = 0;
    logic         rd_pend;
    reg_data_t    rd_exp;
    logic         ack_pend;
    mem_word_t    fetch_exp;
    logic [15:0]  fetch_word_q;
    logic         pix_pend;
    rgb12_t       pix_exp;
    logic         host_mem;

    ////////////////////////////////////////////////////////////
    // Reference model of the memory map
    ////////////////////////////////////////////////////////////

    function automatic region_t classify(regbus_addr_t a);
        if (a <= 19'h1FFFF) begin
            return REGION_MAINRAM;
        end
        if (a >= 19'h40200 && a <= 19'h403FF) begin
            return REGION_PALETTE;
        end
        return REGION_NONE;
    endfunction

    function automatic reg_data_t expected_read(regbus_addr_t a);
        case (classify(a))
            REGION_MAINRAM: return ram_model[a[16:0]];
            REGION_PALETTE: return pal_model[a[8:0]];
            default:        return 8'h00;
        endcase
    endfunction

    // Lowest byte address lands in bits 7:0
    function automatic mem_word_t expected_fetch(logic [15:0] w);
        logic [16:0] base;
        base = {w[14:0], 2'b00};
        return {ram_model[base | 17'd3], ram_model[base | 17'd2],
                ram_model[base | 17'd1], ram_model[base]};
    endfunction

    function automatic rgb12_t expected_rgb(palette_idx_t idx);
        palette_entry_t entry;
        entry = {pal_model[{idx, 1'b1}], pal_model[{idx, 1'b0}]};
        return entry[11:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare, then take this edge's requests into the model
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            rd_pend  = 1'b0;
            ack_pend = 1'b0;
            pix_pend = 1'b0;
            for (int i = 0; i < 512; i++) begin
                pal_written[i] = 1'b0;
            end
        end else begin
            if (rd_pend && rddata_i !== rd_exp) begin
                $display("ERR %0t rddata_o: expected %h, actual %h", $time, rd_exp, rddata_i);
                value_errors++;
            end
            if (ack_pend && fetch_ack_i !== 1'b1) begin
                $display("Fetch of word %h was granted but no ack followed at %0t",
                         fetch_word_q, $time);
                protocol_errors++;
            end else if (ack_pend && fetch_data_i !== fetch_exp) begin
                $display("ERR %0t fetch_data_o: expected %h, actual %h",
                         $time, fetch_exp, fetch_data_i);
                value_errors++;
            end else if (!ack_pend && fetch_ack_i !== 1'b0) begin
                $display("Fetch ack seen at %0t without a grant the cycle before", $time);
                protocol_errors++;
            end
            if (pix_pend && pixel_rgb_i !== pix_exp) begin
                $display("ERR %0t pixel_rgb_o: expected %h, actual %h", $time, pix_exp, pixel_rgb_i);
                value_errors++;
            end

            // Host main-RAM strobe blocks the fetch grant
            host_mem     = regbus_req_i.strobe && (classify(regbus_req_i.addr) == REGION_MAINRAM);
            rd_pend      = regbus_req_i.strobe && !regbus_req_i.write;
            rd_exp       = expected_read(regbus_req_i.addr);
            ack_pend     = fetch_strobe_i && !host_mem;
            fetch_word_q = fetch_addr_i;
            fetch_exp    = expected_fetch(fetch_addr_i);
            pix_pend     = pal_written[{pixel_idx_i, 1'b0}] && pal_written[{pixel_idx_i, 1'b1}];
            pix_exp      = expected_rgb(pixel_idx_i);

            if (regbus_req_i.strobe && regbus_req_i.write) begin
                case (classify(regbus_req_i.addr))
                    REGION_MAINRAM: ram_model[regbus_req_i.addr[16:0]] = regbus_req_i.wrdata;
                    REGION_PALETTE: begin
                        pal_model[regbus_req_i.addr[8:0]]   = regbus_req_i.wrdata;
                        pal_written[regbus_req_i.addr[8:0]] = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign value_errors_o    = value_errors;
    assign protocol_errors_o = protocol_errors;

endmodule

// ==== verification/tb_vera_core.sv ====
`timescale 1ns/1ps

module tb_vera_core;

    import vera_bus_pkg::*;
    import vera_video_pkg::*;

    localparam int RAM_FILL    = 4096;
    localparam int PAL_FILL    = 512;
    localparam int RAM_OPS     = 600;
    localparam int MISC_OPS    = 300;
    localparam int FETCHES     = 100;
    localparam int BURST_LEN   = 24;
    localparam int PLANNED_OPS = RAM_FILL + PAL_FILL + RAM_OPS + MISC_OPS + FETCHES + BURST_LEN;
    localparam int WATCHDOG_NS = 2 * PLANNED_OPS * 4 * 100;

    logic         clk;
    logic         reset;
    regbus_req_t  regbus_req;
    reg_data_t    rddata;
    logic         fetch_strobe;
    logic [15:0]  fetch_addr;
    logic         fetch_ack;
    mem_word_t    fetch_data;
    palette_idx_t pixel_idx;
    rgb12_t       pixel_rgb;
    int           value_errors;
    int           protocol_errors;
    int           stim_errors = 0;

    vera_core u_dut (
        .clk            (clk),
        .reset          (reset),
        .regbus_req_i   (regbus_req),
        .rddata_o       (rddata),
        .fetch_strobe_i (fetch_strobe),
        .fetch_addr_i   (fetch_addr),
        .fetch_ack_o    (fetch_ack),
        .fetch_data_o   (fetch_data),
        .pixel_idx_i    (pixel_idx),
        .pixel_rgb_o    (pixel_rgb)
    );

    vera_core_checker u_checker (
        .clk               (clk),
        .reset             (reset),
        .regbus_req_i      (regbus_req),
        .rddata_i          (rddata),
        .fetch_strobe_i    (fetch_strobe),
        .fetch_addr_i      (fetch_addr),
        .fetch_ack_i       (fetch_ack),
        .fetch_data_i      (fetch_data),
        .pixel_idx_i       (pixel_idx),
        .pixel_rgb_i       (pixel_rgb),
        .value_errors_o    (value_errors),
        .protocol_errors_o (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // One clock of host traffic with a fresh pixel index
    task automatic host_cycle(input logic strobe, input regbus_addr_t addr,
                              input logic wr, input reg_data_t data);
        logic [31:0] r;
        @(posedge clk);
        regbus_req <= '{addr: addr, wrdata: data, strobe: strobe, write: wr};
        r = $urandom;
        pixel_idx <= r[7:0];
    endtask

    // Host idle until the held fetch is acked
    task automatic wait_fetch_ack(input int limit);
        int waited;
        waited = 0;
        do begin
            host_cycle(1'b0, '0, 1'b0, '0);
            waited++;
        end while (!fetch_ack && waited < limit);
        fetch_strobe <= 1'b0;
        if (!fetch_ack) begin
            $display("No fetch ack for word %h within %0d cycles", fetch_addr, limit);
            stim_errors++;
        end
    endtask

    initial begin
        logic [31:0]  r;
        regbus_addr_t addr;
        reset        = 1'b1;
        regbus_req   = '0;
        fetch_strobe = 1'b0;
        fetch_addr   = '0;
        pixel_idx    = '0;
        void'($urandom(10));
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Fill the tested part of main RAM and then every palette byte
        for (int i = 0; i < RAM_FILL; i++) begin
            r = $urandom;
            host_cycle(1'b1, regbus_addr_t'(i), 1'b1, r[7:0]);
        end
        for (int i = 0; i < PAL_FILL; i++) begin
            r = $urandom;
            host_cycle(1'b1, {10'h201, 9'(i)}, 1'b1, r[7:0]);
        end

        // Mixed main RAM reads and writes with idle gaps
        for (int i = 0; i < RAM_OPS; i++) begin
            r = $urandom;
            host_cycle(r[31] | r[30], regbus_addr_t'(r[11:0]), r[29], r[19:12]);
        end

        // Palette traffic and unmapped addresses
        for (int i = 0; i < MISC_OPS; i++) begin
            r = $urandom;
            case (r[1:0])
                2'd0, 2'd1: addr = {10'h201, r[10:2]};
                2'd2:       addr = {2'b01, r[18:2]};
                default:    addr = r[19] ? {10'h200, r[10:2]} : {2'b11, r[18:2]};
            endcase
            host_cycle(1'b1, addr, r[31], r[27:20]);
        end

        ////////////////////////////////////////////////////////////
        // Fetch master
        ////////////////////////////////////////////////////////////

        for (int i = 0; i < FETCHES; i++) begin
            r = $urandom;
            host_cycle(1'b0, '0, 1'b0, '0);
            fetch_strobe <= 1'b1;
            fetch_addr   <= {6'd0, r[9:0]};
            wait_fetch_ack(4);
        end

        // Host reads every cycle while a fetch is held
        for (int i = 0; i < BURST_LEN; i++) begin
            r = $urandom;
            host_cycle(1'b1, regbus_addr_t'(r[11:0]), 1'b0, '0);
            fetch_strobe <= 1'b1;
            fetch_addr   <= 16'h0155;
        end
        // Host drops out on the first cycle and the ack may take two more
        wait_fetch_ack(3);
        repeat (4) host_cycle(1'b0, '0, 1'b0, '0);
        @(negedge clk);

        $display("Errors: value %0d, protocol %0d, stimulus %0d",
                 value_errors, protocol_errors, stim_errors);
        if (value_errors + protocol_errors + stim_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the run finished", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== vera_core.f ====
design/vera_bus_pkg.sv
design/vera_video_pkg.sv
design/main_ram.sv
design/membus_arbiter.sv
design/palette_ram.sv
design/regbus_decoder.sv
design/vera_core.sv
verification/vera_core_checker.sv
verification/tb_vera_core.sv

// ==== Makefile ====
# Verilator flow for the vera_core bus side
FILELIST = vera_core.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f $(FILELIST) --top-module tb_vera_core

sim:
	verilator --binary --timing --assert -f $(FILELIST) --top-module tb_vera_core
	./obj_dir/Vtb_vera_core | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
